//--- tb.f
+incdir+source
source/Types.sv
source/DataMemoryBus.sv
source/InstDecoder.sv
source/DatapathController.sv
source/IntegerALU.sv
source/RegisterFile.sv
source/ProcessorSC.sv
source/DataMemory.sv
source/ProcessorSystem.sv
sim/ProcessorSystem_asserts.sv
sim/ProcessorSystem_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ProcessorSystem_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, fail unless the pass line is printed"
	@echo "  clean  remove the build directory $(OBJ_DIR)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/ProcessorSystem_tb.sv
module ProcessorSystem_tb
    import Types::*;
();

    localparam int  RESET_CYCLES  = 10;
    localparam int  RESET_TIMEOUT = 40;            // Wake-ups allowed before release
    localparam int  RUN_TIMEOUT   = 200;           // Cycles for the whole program
    localparam Word NOP           = 32'h0000_0013; // ADDI x0,x0,0

    typedef struct packed {
        Word    Pc;        // Expected fetch address
        Word    Inst;      // Word presented on i_Inst
        logic   RegWr;     // Expected register write
        RegAddr RegWrAddr;
        Word    RegWrData;
        logic   MemWr;     // Expected memory write
        Word    MemWrAddr;
        Word    MemWrData;
    } StepEntry;

    logic   Clock = 1'b0;
    logic   arstN;
    Word    Inst;
    Word    InstAddr;
    logic   RegWrEnable;
    RegAddr RegWrAddr;
    Word    RegWrData;
    logic   MemWrEnable;
    Word    MemWrAddr;
    Word    MemWrData;

    StepEntry Steps [$]; // Execution order
    Word      BuildPc;   // Running PC while the table is built
    int       StepIdx;

    ProcessorSystem DUT (
        .i_Clock       (Clock),
        .i_arstN       (arstN),
        .i_Inst        (Inst),
        .o_InstAddr    (InstAddr),
        .o_RegWrEnable (RegWrEnable),
        .o_RegWrAddr   (RegWrAddr),
        .o_RegWrData   (RegWrData),
        .o_MemWrEnable (MemWrEnable),
        .o_MemWrAddr   (MemWrAddr),
        .o_MemWrData   (MemWrData));

    initial begin
        forever #5 Clock = ~Clock;
    end

    // Reset released on a falling edge
    initial begin
        arstN = 1'b0;
        repeat (RESET_CYCLES) @(negedge Clock);
        arstN = 1'b1;
    end

    // ------------------------------------------------------------
    // Failure reporting and compare tasks
    // ------------------------------------------------------------

    task automatic stopOnFailure();
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at first failure");
    endtask

    task automatic abortRun(string Why);
        $display("ERROR at %0t: %s", $time, Why);
        stopOnFailure();
    endtask

    task automatic mismatch(string Name, string Actual, string Expected);
        $display("CHECK FAILED at %0t: %s is %s, expected %s", $time, Name, Actual, Expected);
        stopOnFailure();
    endtask

    task automatic checkWord(string Name, Word Actual, Word Expected);
        if (Actual !== Expected) begin
            mismatch(Name, $sformatf("%h", Actual), $sformatf("%h", Expected));
        end
    endtask

    task automatic checkRegAddr(string Name, RegAddr Actual, RegAddr Expected);
        if (Actual !== Expected) begin
            mismatch(Name, $sformatf("x%0d", Actual), $sformatf("x%0d", Expected));
        end
    endtask

    task automatic checkBit(string Name, logic Actual, logic Expected);
        if (Actual !== Expected) begin
            mismatch(Name, $sformatf("%b", Actual), $sformatf("%b", Expected));
        end
    endtask

    // ------------------------------------------------------------
    // Instruction encoders, RV32I formats
    // ------------------------------------------------------------

    function automatic Word encodeR(logic [6:0] F7, RegAddr Rs2, RegAddr Rs1,
                                    logic [2:0] F3, RegAddr Rd);
        return {F7, Rs2, Rs1, F3, Rd, OPC_OP};
    endfunction

    function automatic Word encodeI(logic [11:0] Imm, RegAddr Rs1, logic [2:0] F3,
                                    RegAddr Rd, Opcode Op);
        return {Imm, Rs1, F3, Rd, Op};
    endfunction

    function automatic Word encodeS(logic [11:0] Imm, RegAddr Rs2, RegAddr Rs1);
        return {Imm[11:5], Rs2, Rs1, 3'b010, Imm[4:0], OPC_STORE}; // SW only
    endfunction

    function automatic Word encodeB(logic [12:0] Imm, RegAddr Rs2, RegAddr Rs1,
                                    logic [2:0] F3);
        return {Imm[12], Imm[10:5], Rs2, Rs1, F3, Imm[4:1], Imm[11], OPC_BRANCH};
    endfunction

    function automatic Word encodeU(logic [19:0] Imm, RegAddr Rd);
        return {Imm, Rd, OPC_LUI};
    endfunction

    function automatic Word encodeJ(logic [20:0] Imm, RegAddr Rd);
        return {Imm[20], Imm[10:1], Imm[11], Imm[19:12], Rd, OPC_JAL};
    endfunction

    function automatic Word signExtend12(logic [11:0] Imm);
        return {{20{Imm[11]}}, Imm};
    endfunction

    // ------------------------------------------------------------
    // Table construction
    // ------------------------------------------------------------

    task automatic addStep(Word I, logic RegWr, RegAddr Rd, Word RegData,
                           logic MemWr, Word MemAddr, Word MemData, Word NextPc);
        Steps.push_back('{BuildPc, I, RegWr, Rd, RegData, MemWr, MemAddr, MemData});
        BuildPc = NextPc;
    endtask

    task automatic expectRegWrite(Word I, RegAddr Rd, Word Value);
        addStep(I, 1'b1, Rd, Value, 1'b0, '0, '0, BuildPc + 32'd4);
    endtask

    task automatic expectMemWrite(Word I, Word Addr, Word Data);
        addStep(I, 1'b0, '0, '0, 1'b1, Addr, Data, BuildPc + 32'd4);
    endtask

    task automatic expectNoWrite(Word I, Word NextPc); // Branches and x0 targets
        addStep(I, 1'b0, '0, '0, 1'b0, '0, '0, NextPc);
    endtask

    task automatic expectLink(Word I, RegAddr Rd, Word NextPc);
        addStep(I, 1'b1, Rd, BuildPc + 32'd4, 1'b0, '0, '0, NextPc);
    endtask

    // LUI then ADDI, upper part rounded for the signed low part
    task automatic loadConstant(RegAddr Rd, Word Value);
        logic [19:0] Upper;
        Upper = Value[31:12] + {19'b0, Value[11]};
        expectRegWrite(encodeU(Upper, Rd), Rd, {Upper, 12'b0});
        expectRegWrite(encodeI(Value[11:0], Rd, 3'b000, Rd, OPC_OP_IMM), Rd,
                       {Upper, 12'b0} + signExtend12(Value[11:0]));
    endtask

    task automatic buildProgram();
        Word A, B, Link16, Link17;
        A       = $urandom();
        B       = $urandom();
        BuildPc = '0;
        loadConstant(5'd1, A);
        loadConstant(5'd2, B);
        expectRegWrite(encodeR(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, A + B);
        expectRegWrite(encodeR(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, A - B);
        expectRegWrite(encodeR(7'b0000000, 5'd2, 5'd1, 3'b111, 5'd5), 5'd5, A & B);
        expectRegWrite(encodeR(7'b0000000, 5'd2, 5'd1, 3'b110, 5'd6), 5'd6, A | B);
        expectRegWrite(encodeR(7'b0000000, 5'd2, 5'd1, 3'b100, 5'd7), 5'd7, A ^ B);
        expectRegWrite(encodeR(7'b0000000, 5'd2, 5'd1, 3'b010, 5'd8), 5'd8,
                       {31'b0, $signed(A) < $signed(B)});
        expectRegWrite(encodeR(7'b0000000, 5'd1, 5'd2, 3'b010, 5'd9), 5'd9,
                       {31'b0, $signed(B) < $signed(A)});
        expectNoWrite(encodeI(12'd5, 5'd1, 3'b000, 5'd0, OPC_OP_IMM), BuildPc + 32'd4);
        expectRegWrite(encodeR(7'b0000000, 5'd1, 5'd0, 3'b000, 5'd10), 5'd10, A); // x0 reads 0
        // Base 16, then SW and LW through it
        expectRegWrite(encodeI(12'd16, 5'd0, 3'b000, 5'd11, OPC_OP_IMM), 5'd11, 32'd16);
        expectMemWrite(encodeS(12'd8, 5'd1, 5'd11), 32'd24, A);
        expectMemWrite(encodeS(12'd12, 5'd2, 5'd11), 32'd28, B);
        expectRegWrite(encodeI(12'd8, 5'd11, 3'b010, 5'd12, OPC_LOAD), 5'd12, A);
        expectRegWrite(encodeI(12'd12, 5'd11, 3'b010, 5'd13, OPC_LOAD), 5'd13, B);
        expectNoWrite(encodeB(13'd8, 5'd1, 5'd12, 3'b000), BuildPc + 32'd8); // BEQ taken
        expectNoWrite(encodeB(13'd8, 5'd2, 5'd1, 3'b000),
                      (A == B) ? BuildPc + 32'd8 : BuildPc + 32'd4);
        expectRegWrite(encodeI(12'hFFB, 5'd0, 3'b000, 5'd14, OPC_OP_IMM), 5'd14, 32'hFFFF_FFFB);
        expectRegWrite(encodeI(12'd3, 5'd0, 3'b000, 5'd15, OPC_OP_IMM), 5'd15, 32'd3);
        expectNoWrite(encodeB(13'd12, 5'd15, 5'd14, 3'b100), BuildPc + 32'd12); // -5 < 3
        expectNoWrite(encodeB(13'd8, 5'd14, 5'd15, 3'b100), BuildPc + 32'd4);
        expectNoWrite(encodeB(13'd8, 5'd2, 5'd1, 3'b100),
                      ($signed(A) < $signed(B)) ? BuildPc + 32'd8 : BuildPc + 32'd4);
        Link16 = BuildPc + 32'd4;
        expectLink(encodeJ(21'd16, 5'd16), 5'd16, BuildPc + 32'd16);
        expectRegWrite(encodeI(12'd201, 5'd0, 3'b000, 5'd18, OPC_OP_IMM), 5'd18, 32'd201);
        Link17 = BuildPc + 32'd4;
        // Odd target, bit 0 cleared by JALR
        expectLink(encodeI(12'd4, 5'd18, 3'b000, 5'd17, OPC_JALR), 5'd17,
                   (32'd201 + 32'd4) & ~32'd1);
        expectRegWrite(encodeR(7'b0000000, 5'd17, 5'd16, 3'b000, 5'd19), 5'd19, Link16 + Link17);
    endtask

    task automatic checkStep(StepEntry E);
        checkWord("o_InstAddr", InstAddr, E.Pc);
        checkBit("o_RegWrEnable", RegWrEnable, E.RegWr);
        if (E.RegWr) begin
            checkRegAddr("o_RegWrAddr", RegWrAddr, E.RegWrAddr);
            checkWord("o_RegWrData", RegWrData, E.RegWrData);
        end
        checkBit("o_MemWrEnable", MemWrEnable, E.MemWr);
        if (E.MemWr) begin
            checkWord("o_MemWrAddr", MemWrAddr, E.MemWrAddr);
            checkWord("o_MemWrData", MemWrData, E.MemWrData);
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------

    initial begin
        int Wakes;
        int Cycles;
        Inst = NOP; // Held through reset
        void'($urandom(32'h548c));
        buildProgram();

        // Wake on each falling edge or on release, whichever runs first
        Wakes = 0;
        while (arstN !== 1'b1) begin
            if (Wakes >= RESET_TIMEOUT) begin
                abortRun("reset was never released");
            end
            @(posedge arstN or negedge Clock);
            Wakes++;
            if (arstN !== 1'b1) begin
                checkWord("o_InstAddr", InstAddr, '0);
                checkBit("o_RegWrEnable", RegWrEnable, 1'b0);
                checkBit("o_MemWrEnable", MemWrEnable, 1'b0);
            end
        end

        StepIdx = 0;
        Cycles  = 0;
        while (StepIdx < Steps.size()) begin
            if (Cycles >= RUN_TIMEOUT) begin
                abortRun("program did not finish within the cycle limit");
            end
            Inst = Steps[StepIdx].Inst; // Falling edge
            #2;                         // Trace settled, well before the rising edge
            checkStep(Steps[StepIdx]);
            StepIdx++;
            Cycles++;
            @(negedge Clock);
        end
        Inst = NOP;
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- sim/ProcessorSystem_asserts.sv
module ProcessorSystem_asserts
    import Types::*;
(
    input logic   i_Clock,
    input logic   i_arstN,
    input Word    i_PC,          // Core PC register
    input logic   i_RegWrEnable, // Masked register write
    input RegAddr i_RegWrAddr,
    input logic   i_MemWrEnable
);

    // ------------------------------------------------------------
    // Core invariants
    // ------------------------------------------------------------

    PcAligned: assert property (@(posedge i_Clock) disable iff (!i_arstN)
        i_PC[1:0] == 2'b00)
        else $error("PC not word aligned, %h", i_PC);

    NoX0Write: assert property (@(posedge i_Clock) disable iff (!i_arstN)
        i_RegWrEnable |-> (i_RegWrAddr != '0))
        else $error("Register write enabled for x0");

    OneWritePerCycle: assert property (@(posedge i_Clock) disable iff (!i_arstN)
        !(i_RegWrEnable && i_MemWrEnable))
        else $error("Register and memory write in the same cycle");

    // First edge out of reset still fetches from zero
    PcZeroAfterReset: assert property (@(posedge i_Clock)
        $rose(i_arstN) |-> (i_PC == '0))
        else $error("PC not zero after reset release, %h", i_PC);

endmodule

bind ProcessorSC ProcessorSystem_asserts CoreChecks (
    .i_Clock       (i_Clock),
    .i_arstN       (i_arstN),
    .i_PC          (PC),
    .i_RegWrEnable (RegWrEnable),
    .i_RegWrAddr   (RD),
    .i_MemWrEnable (MemWrEnable));

//--- source/ProcessorSystem.sv
module ProcessorSystem
    import Types::*;
(
    input  logic   i_Clock,       // System clock
    input  logic   i_arstN,       // Async reset, active low
    input  Word    i_Inst,        // Instruction from external memory
    output Word    o_InstAddr,    // Instruction address
    output logic   o_RegWrEnable, // Register write trace
    output RegAddr o_RegWrAddr,
    output Word    o_RegWrData,
    output logic   o_MemWrEnable, // Memory write trace
    output Word    o_MemWrAddr,
    output Word    o_MemWrData
);

    // ------------------------------------------------------------
    // Core and data memory
    // ------------------------------------------------------------

    DataMemoryBus DBus ();

    ProcessorSC Core (
        .i_Clock       (i_Clock),
        .i_arstN       (i_arstN),
        .i_Inst        (i_Inst),
        .o_InstAddr    (o_InstAddr),
        .o_RegWrEnable (o_RegWrEnable),
        .o_RegWrAddr   (o_RegWrAddr),
        .o_RegWrData   (o_RegWrData),
        .DBus          (DBus.Master));

    DataMemory Mem (
        .i_Clock (i_Clock),
        .i_arstN (i_arstN),
        .Bus     (DBus.Slave));

    // Memory trace straight off the bus
    assign o_MemWrEnable = DBus.WrEnable;
    assign o_MemWrAddr   = DBus.Addr;
    assign o_MemWrData   = DBus.WrData;

endmodule

//--- source/DataMemory.sv
`include "RV_params.svh"

module DataMemory
    import Types::*;
#(
    parameter int DEPTH = `RV_DMEM_DEPTH) // Words, power of two
(
    input  logic        i_Clock, // Write clock
    input  logic        i_arstN, // Clears storage
    DataMemoryBus.Slave Bus      // Access from the core
);

    localparam int IDX_WIDTH = $clog2(DEPTH);

    Word                  Mem [DEPTH];
    logic [IDX_WIDTH-1:0] Index; // Word index, wraps at DEPTH

    assign Index = Bus.Addr[IDX_WIDTH+1:2];

    // ------------------------------------------------------------
    // Clocked write, combinational read
    // ------------------------------------------------------------

    always_ff @(posedge i_Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            for (int i = 0; i < DEPTH; i++) begin
                Mem[i] <= '0;
            end
        end else if (Bus.WrEnable) begin
            Mem[Index] <= Bus.WrData;
        end
    end

    assign Bus.RdData = Mem[Index];

endmodule

//--- source/ProcessorSC.sv
module ProcessorSC
    import Types::*;
(
    input  logic         i_Clock,       // Core clock
    input  logic         i_arstN,       // Async reset, active low
    input  Word          i_Inst,        // Instruction at o_InstAddr
    output Word          o_InstAddr,    // Fetch address
    output logic         o_RegWrEnable, // Register write trace
    output RegAddr       o_RegWrAddr,
    output Word          o_RegWrData,
    DataMemoryBus.Master DBus           // Data memory
);

    Word         PC;            // Current PC
    Word         PCNext;        // PC for next cycle
    Word         PCPlus4;
    Word         PCPlusOffset;  // Branch and JAL target
    Word         RS1PlusOffset; // JALR target
    RegAddr      RS1, RS2, RD;
    Word         Imm;
    Word         RdDataA, RdDataB;
    AluOp        AluControl;
    logic        RegWrEnable;
    logic        MemWrEnable;
    OperandASel  OpASel;
    OperandBSel  OpBSel;
    RegWrDataSel WrDataSel;
    PCNextSel    NextSel;
    Word         OperandA, OperandB;
    Word         AluResult;
    Word         RegWrData;     // Write-back value

    // ------------------------------------------------------------
    // Decode and control
    // ------------------------------------------------------------

    InstDecoder Dec (
        .i_Inst (i_Inst),
        .o_RS1  (RS1),
        .o_RS2  (RS2),
        .o_RD   (RD),
        .o_IMM  (Imm));

    DatapathController DpCtrl (
        .i_Inst         (i_Inst),
        .i_RdDataA      (RdDataA),
        .i_RdDataB      (RdDataB),
        .o_AluControl   (AluControl),
        .o_RegWrEnable  (RegWrEnable),
        .o_MemWrEnable  (MemWrEnable),
        .o_OperandASel  (OpASel),
        .o_OperandBSel  (OpBSel),
        .o_RegWrDataSel (WrDataSel),
        .o_PCNextSel    (NextSel));

    RegisterFile Regs (
        .i_Clock    (i_Clock),
        .i_arstN    (i_arstN),
        .i_WrEnable (RegWrEnable),
        .i_WrAddr   (RD),
        .i_WrData   (RegWrData),
        .i_RdAddrA  (RS1),
        .o_RdDataA  (RdDataA),
        .i_RdAddrB  (RS2),
        .o_RdDataB  (RdDataB));

    // ------------------------------------------------------------
    // Execute and write-back
    // ------------------------------------------------------------

    always_comb begin
        case (OpASel)
            OPA_PC:   OperandA = PC;
            OPA_ZERO: OperandA = '0;      // LUI
            default:  OperandA = RdDataA; // rs1
        endcase
    end

    assign OperandB = (OpBSel == OPB_REG) ? RdDataB : Imm;

    IntegerALU Alu (
        .i_Op       (AluControl),
        .i_OperandA (OperandA),
        .i_OperandB (OperandB),
        .o_Result   (AluResult));

    always_comb begin
        case (WrDataSel)
            WB_MEM:      RegWrData = DBus.RdData; // Load
            WB_PC_PLUS4: RegWrData = PCPlus4;     // Link
            default:     RegWrData = AluResult;
        endcase
    end

    // ------------------------------------------------------------
    // Program counter
    // ------------------------------------------------------------

    assign PCPlus4       = PC + 32'd4;
    assign PCPlusOffset  = PC + Imm;
    assign RS1PlusOffset = RdDataA + Imm;

    always_comb begin
        case (NextSel)
            PC_OFFSET:     PCNext = PCPlusOffset;
            PC_RS1_OFFSET: PCNext = {RS1PlusOffset[31:1], 1'b0}; // JALR drops bit 0
            default:       PCNext = PCPlus4;
        endcase
    end

    always_ff @(posedge i_Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            PC <= '0; // Fetch starts at address zero
        end else begin
            PC <= PCNext;
        end
    end

    // Data bus master, address from rs1+imm
    assign DBus.Addr     = AluResult;
    assign DBus.WrEnable = MemWrEnable;
    assign DBus.WrData   = RdDataB;

    assign o_InstAddr    = PC;
    assign o_RegWrEnable = RegWrEnable; // Trace of the pending write
    assign o_RegWrAddr   = RD;
    assign o_RegWrData   = RegWrData;

endmodule

//--- source/RegisterFile.sv
`include "RV_params.svh"

module RegisterFile
    import Types::*;
(
    input  logic   i_Clock,    // Write clock
    input  logic   i_arstN,    // Clears all registers
    input  logic   i_WrEnable, // Write strobe
    input  RegAddr i_WrAddr,   // Write index
    input  Word    i_WrData,   // Write value
    input  RegAddr i_RdAddrA,  // Read port A index
    input  RegAddr i_RdAddrB,  // Read port B index
    output Word    o_RdDataA,  // Read port A value
    output Word    o_RdDataB   // Read port B value
);

    localparam int NUM_REGS = 2 ** `RV_REG_WIDTH;

    Word Regs [NUM_REGS];

    // ------------------------------------------------------------
    // Synchronous write, x0 left untouched
    // ------------------------------------------------------------

    always_ff @(posedge i_Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                Regs[i] <= '0;
            end
        end else if (i_WrEnable && (i_WrAddr != '0)) begin
            Regs[i_WrAddr] <= i_WrData;
        end
    end

    // Asynchronous reads, old value during a write
    assign o_RdDataA = (i_RdAddrA == '0) ? '0 : Regs[i_RdAddrA];
    assign o_RdDataB = (i_RdAddrB == '0) ? '0 : Regs[i_RdAddrB];

endmodule

//--- source/IntegerALU.sv
module IntegerALU
    import Types::*;
(
    input  AluOp i_Op,       // Operation select
    input  Word  i_OperandA, // First operand
    input  Word  i_OperandB, // Second operand
    output Word  o_Result    // Result
);

    // ------------------------------------------------------------
    // Combinational operations
    // ------------------------------------------------------------

    logic LessThan; // Signed A < B

    assign LessThan = ($signed(i_OperandA) < $signed(i_OperandB));

    always_comb begin
        case (i_Op)
            ALU_ADD:   o_Result = i_OperandA + i_OperandB;
            ALU_SUB:   o_Result = i_OperandA - i_OperandB;
            ALU_AND:   o_Result = i_OperandA & i_OperandB;
            ALU_OR:    o_Result = i_OperandA | i_OperandB;
            ALU_XOR:   o_Result = i_OperandA ^ i_OperandB;
            ALU_SLT:   o_Result = {{($bits(Word)-1){1'b0}}, LessThan};
            ALU_PASSB: o_Result = i_OperandB; // LUI path
            default:   o_Result = '0;
        endcase
    end

endmodule

//--- source/DatapathController.sv
module DatapathController
    import Types::*;
(
    input  Word         i_Inst,         // Instruction word
    input  Word         i_RdDataA,      // rs1 value, for branch compare
    input  Word         i_RdDataB,      // rs2 value, for branch compare
    output AluOp        o_AluControl,   // ALU operation
    output logic        o_RegWrEnable,  // Register write, never for x0
    output logic        o_MemWrEnable,  // Data memory write
    output OperandASel  o_OperandASel,  // ALU operand A source
    output OperandBSel  o_OperandBSel,  // ALU operand B source
    output RegWrDataSel o_RegWrDataSel, // Write-back source
    output PCNextSel    o_PCNextSel     // Next PC source
);

    Opcode      Op;
    logic [2:0] Funct3;
    RegAddr     Rd;
    logic       IsSub;       // OP with funct7 bit 5 set
    logic       IsEQ;        // rs1 == rs2
    logic       IsLT;        // rs1 < rs2, signed
    logic       BranchTaken;
    logic       RegWrRaw;    // Write request before x0 masking
    AluOp       ArithOp;     // Operation from funct3

    assign Op     = Opcode'(i_Inst[6:0]);
    assign Funct3 = i_Inst[14:12];
    assign Rd     = i_Inst[11:7];
    assign IsSub  = (Op == OPC_OP) && i_Inst[30];

    // ------------------------------------------------------------
    // Branch compare
    // ------------------------------------------------------------

    assign IsEQ = (i_RdDataA == i_RdDataB);
    assign IsLT = ($signed(i_RdDataA) < $signed(i_RdDataB));

    always_comb begin
        case (Funct3)
            3'b000:  BranchTaken = IsEQ; // BEQ
            3'b100:  BranchTaken = IsLT; // BLT
            default: BranchTaken = 1'b0; // Other branches never taken
        endcase
    end

    // Shared funct3 decode for OP and OP_IMM
    always_comb begin
        case (Funct3)
            3'b111:  ArithOp = ALU_AND;
            3'b110:  ArithOp = ALU_OR;
            3'b100:  ArithOp = ALU_XOR;
            3'b010:  ArithOp = ALU_SLT;
            default: ArithOp = IsSub ? ALU_SUB : ALU_ADD;
        endcase
    end

    // ------------------------------------------------------------
    // Main decode
    // ------------------------------------------------------------

    always_comb begin
        // Defaults behave as a NOP
        o_AluControl   = ALU_ADD;
        RegWrRaw       = 1'b0;
        o_MemWrEnable  = 1'b0;
        o_OperandASel  = OPA_REG;
        o_OperandBSel  = OPB_IMM;
        o_RegWrDataSel = WB_ALU;
        o_PCNextSel    = PC_PLUS4;

        case (Op)
            OPC_OP: begin
                o_AluControl  = ArithOp;
                o_OperandBSel = OPB_REG; // rs2 operand
                RegWrRaw      = 1'b1;
            end
            OPC_OP_IMM: begin
                o_AluControl = ArithOp;
                RegWrRaw     = 1'b1;
            end
            OPC_LUI: begin
                o_AluControl  = ALU_PASSB;
                o_OperandASel = OPA_ZERO;
                RegWrRaw      = 1'b1;
            end
            OPC_LOAD: begin
                o_RegWrDataSel = WB_MEM; // Address from rs1+imm
                RegWrRaw       = 1'b1;
            end
            OPC_STORE: o_MemWrEnable = 1'b1;
            OPC_BRANCH: begin
                o_PCNextSel = BranchTaken ? PC_OFFSET : PC_PLUS4;
            end
            OPC_JAL: begin
                o_RegWrDataSel = WB_PC_PLUS4; // Link address
                o_PCNextSel    = PC_OFFSET;
                RegWrRaw       = 1'b1;
            end
            OPC_JALR: begin
                o_RegWrDataSel = WB_PC_PLUS4;
                o_PCNextSel    = PC_RS1_OFFSET;
                RegWrRaw       = 1'b1;
            end
            default: ; // Unsupported opcode, no side effects
        endcase
    end

    assign o_RegWrEnable = RegWrRaw && (Rd != '0); // x0 never written

endmodule

//--- source/InstDecoder.sv
module InstDecoder
    import Types::*;
(
    input  Word    i_Inst, // Instruction word
    output RegAddr o_RS1,  // Source register 1
    output RegAddr o_RS2,  // Source register 2
    output RegAddr o_RD,   // Destination register
    output Word    o_IMM   // Sign-extended immediate
);

    Opcode Op;

    assign Op    = Opcode'(i_Inst[6:0]);
    assign o_RS1 = i_Inst[19:15];
    assign o_RS2 = i_Inst[24:20];
    assign o_RD  = i_Inst[11:7];

    // ------------------------------------------------------------
    // Immediate by instruction format
    // ------------------------------------------------------------

    always_comb begin
        case (Op)
            OPC_STORE:  // S format
                o_IMM = {{20{i_Inst[31]}}, i_Inst[31:25], i_Inst[11:7]};
            OPC_BRANCH: // B format, bit 0 always zero
                o_IMM = {{20{i_Inst[31]}}, i_Inst[7], i_Inst[30:25],
                         i_Inst[11:8], 1'b0};
            OPC_LUI:    // U format
                o_IMM = {i_Inst[31:12], 12'b0};
            OPC_JAL:    // J format
                o_IMM = {{12{i_Inst[31]}}, i_Inst[19:12], i_Inst[20],
                         i_Inst[30:21], 1'b0};
            default:    // I format for OP_IMM, LOAD, JALR
                o_IMM = {{20{i_Inst[31]}}, i_Inst[31:20]};
        endcase
    end

endmodule

//--- source/DataMemoryBus.sv
interface DataMemoryBus
    import Types::*;
();

    Word  Addr;     // Byte address
    logic WrEnable; // Write at next rising edge
    Word  WrData;   // Store data
    Word  RdData;   // Load data, combinational

    // Core side
    modport Master (
        output Addr,
        output WrEnable,
        output WrData,
        input  RdData);

    // Memory side
    modport Slave (
        input  Addr,
        input  WrEnable,
        input  WrData,
        output RdData);

endinterface

//--- source/Types.sv
`include "RV_params.svh"

package Types;

    typedef logic [`RV_DATA_WIDTH-1:0] Word;    // Data and address word
    typedef logic [`RV_REG_WIDTH-1:0]  RegAddr; // Register index

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } Opcode;

    // ALU operations
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASSB
    } AluOp;

    // Datapath selectors
    typedef enum logic [1:0] {PC_PLUS4, PC_OFFSET, PC_RS1_OFFSET} PCNextSel;

    typedef enum logic [1:0] {OPA_REG, OPA_PC, OPA_ZERO} OperandASel;

    typedef enum logic {OPB_REG, OPB_IMM} OperandBSel;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC_PLUS4} RegWrDataSel;

endpackage

//--- source/RV_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// ------------------------------------------------------------
// Core widths
// ------------------------------------------------------------

// Data word and address width
`define RV_DATA_WIDTH 32

// Register index width, 32 registers
`define RV_REG_WIDTH 5

// ------------------------------------------------------------
// Data memory
// ------------------------------------------------------------

`define RV_DMEM_DEPTH 64 // Words, power of two

`endif
